/* hw/icache_pkg.sv */
// icache address fields, sizes, FSM states, and bus and way structs
`default_nettype none

package icache_pkg;

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int TAG_W    = 23;
  localparam int INDEX_W  = 6;
  localparam int OFFSET_W = 3;
  localparam int SETS     = 64; // 2**INDEX_W
  localparam int WAYS     = 2;

  // field positions inside an address
  localparam int INDEX_LSB = OFFSET_W;           // bit 3
  localparam int TAG_LSB   = OFFSET_W + INDEX_W; // bit 9

  typedef logic [ADDR_W-1:0]         addr_t;
  typedef logic [TAG_W-1:0]          tag_t;
  typedef logic [INDEX_W-1:0]        index_t;
  typedef logic [DATA_W-1:0]         data_t;
  typedef logic [$clog2(WAYS)-1:0]   way_t;
  typedef logic [1:0]                resp_t;

  localparam resp_t RESP_OK = 2'b00; // anything else is an error

  // memory answer and cpu answer
  typedef struct packed {
    resp_t resp;
    data_t data;
  } rsp_t;

  // one way's result for the looked-up set
  typedef struct packed {
    logic  hit;
    data_t data;
  } lookup_t;

  // line written into a way on refill
  typedef struct packed {
    index_t index;
    tag_t   tag;
    data_t  data;
  } fill_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MEM_AR,
    MEM_R,
    RESP
  } state_e;

endpackage

`default_nettype wire

/* hw/icache_sram.sv */
// single-port 64-entry memory with registered read, word type as parameter
`default_nettype none

module icache_sram #(
  parameter type word_t = logic
) (
  input  wire logic               clk,
  input  wire logic               en_i,
  input  wire logic               we_i,
  input  wire icache_pkg::index_t addr_i,
  input  wire word_t              wdata_i,
  output word_t                   rdata_o
);

  word_t mem [icache_pkg::SETS]; // contents are undefined until filled

  // one access per cycle, write has priority over read
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i]; // holds while not read
      end
    end
  end

endmodule

`default_nettype wire

/* hw/icache_way.sv */
// one cache way: tag and data memories, valid bits and tag compare
`default_nettype none

module icache_way (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                rd_en_i,
  input  wire icache_pkg::index_t  rd_index_i,
  input  wire icache_pkg::tag_t    cmp_tag_i,
  input  wire logic                fill_en_i,
  input  wire icache_pkg::fill_t   fill_i,
  output icache_pkg::lookup_t      lookup_o,
  output logic                     set_valid_o
);

  logic [icache_pkg::SETS-1:0] valid_q;    // one bit per set
  logic                        valid_rd_q; // valid bit of the set being read
  logic                        mem_en;
  icache_pkg::index_t          mem_addr;
  icache_pkg::tag_t            tag_rd;
  icache_pkg::data_t           data_rd;

  // fill and lookup never fall in the same cycle
  assign mem_en   = rd_en_i | fill_en_i;
  assign mem_addr = fill_en_i ? fill_i.index : rd_index_i;

  icache_sram #(
    .word_t (icache_pkg::tag_t)
  ) u_tag (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (fill_en_i),
    .addr_i  (mem_addr),
    .wdata_i (fill_i.tag),
    .rdata_o (tag_rd)
  );

  icache_sram #(
    .word_t (icache_pkg::data_t)
  ) u_data (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (fill_en_i),
    .addr_i  (mem_addr),
    .wdata_i (fill_i.data),
    .rdata_o (data_rd)
  );

  // valid bits live in flops so reset can clear them
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q    <= '0;
      valid_rd_q <= 1'b0;
    end else begin
      if (fill_en_i) begin
        valid_q[fill_i.index] <= 1'b1;
      end
      if (rd_en_i) begin
        valid_rd_q <= valid_q[rd_index_i]; // lines up with the sram read
      end
    end
  end

  always_comb begin
    lookup_o.hit  = valid_rd_q & (tag_rd == cmp_tag_i);
    lookup_o.data = data_rd;
  end

  assign set_valid_o = valid_rd_q; // used for victim choice

endmodule

`default_nettype wire

/* hw/icache_ctrl.sv */
// icache controller FSM: lookup, refill, victim choice and bus handshakes
`default_nettype none

module icache_ctrl (
  input  wire logic                                        clk,
  input  wire logic                                        rst,
  // cpu side
  input  wire logic                                        ar_valid_i,
  output logic                                             ar_ready_o,
  input  wire icache_pkg::addr_t                           ar_addr_i,
  output logic                                             r_valid_o,
  input  wire logic                                        r_ready_i,
  output icache_pkg::rsp_t                                 r_rsp_o,
  // memory side
  output logic                                             mem_ar_valid_o,
  input  wire logic                                        mem_ar_ready_i,
  output icache_pkg::addr_t                                mem_ar_addr_o,
  output logic                                             mem_r_ready_o,
  input  wire logic                                        mem_r_valid_i,
  input  wire icache_pkg::rsp_t                            mem_r_rsp_i,
  // toward the ways
  output logic                                             rd_en_o,
  output icache_pkg::index_t                               rd_index_o,
  output icache_pkg::tag_t                                 cmp_tag_o,
  output logic [icache_pkg::WAYS-1:0]                      fill_en_o,
  output icache_pkg::fill_t                                fill_o,
  // from the ways
  input  wire icache_pkg::lookup_t [icache_pkg::WAYS-1:0]  lookup_i,
  input  wire logic [icache_pkg::WAYS-1:0]                 set_valid_i
);

  localparam int ADDR_W    = icache_pkg::ADDR_W;
  localparam int TAG_LSB   = icache_pkg::TAG_LSB;
  localparam int INDEX_LSB = icache_pkg::INDEX_LSB;

  icache_pkg::state_e state_q;
  icache_pkg::addr_t  addr_q;   // request address, offset cleared
  icache_pkg::rsp_t   rsp_q;    // answer held for the cpu
  icache_pkg::way_t   victim_q; // way to refill
  icache_pkg::way_t   rand_q;   // free-running replacement counter
  icache_pkg::way_t   victim;
  icache_pkg::data_t  hit_data;
  logic               hit_any;
  logic               ar_fire;
  logic               beat;
  logic               fill_ok;

  assign ar_ready_o = (state_q == icache_pkg::IDLE);
  assign ar_fire    = ar_valid_i & ar_ready_o;
  assign beat       = mem_r_valid_i & mem_r_ready_o; // only high in MEM_R
  assign fill_ok    = beat && (mem_r_rsp_i.resp == icache_pkg::RESP_OK);

  // lookup is issued straight from the cpu request
  assign rd_en_o       = ar_fire;
  assign rd_index_o    = ar_addr_i[TAG_LSB-1:INDEX_LSB];
  assign cmp_tag_o     = addr_q[ADDR_W-1:TAG_LSB];
  assign mem_ar_addr_o = addr_q;
  assign r_rsp_o       = rsp_q;

  // combine the per-way hits
  always_comb begin
    hit_any  = 1'b0;
    hit_data = '0;
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (lookup_i[w].hit) begin
        hit_any  = 1'b1;
        hit_data = lookup_i[w].data;
      end
    end
  end

  // lowest invalid way wins, counter otherwise
  always_comb begin
    victim = rand_q;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
      if (!set_valid_i[w]) begin
        victim = icache_pkg::way_t'(w);
      end
    end
  end

  // error responses are never installed
  always_comb begin
    fill_en_o = '0;
    if (fill_ok) begin
      fill_en_o[victim_q] = 1'b1;
    end
    fill_o.index = addr_q[TAG_LSB-1:INDEX_LSB];
    fill_o.tag   = addr_q[ADDR_W-1:TAG_LSB];
    fill_o.data  = mem_r_rsp_i.data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= icache_pkg::IDLE;
      r_valid_o      <= 1'b0;
      mem_ar_valid_o <= 1'b0;
      mem_r_ready_o  <= 1'b0;
      rand_q         <= '0;
    end else begin
      rand_q <= rand_q + icache_pkg::way_t'(1);
      case (state_q)
        icache_pkg::IDLE: begin
          if (ar_fire) begin
            state_q <= icache_pkg::LOOKUP;
          end
        end
        icache_pkg::LOOKUP: begin
          state_q <= hit_any ? icache_pkg::RESP : icache_pkg::MEM_AR;
        end
        icache_pkg::MEM_AR: begin
          if (!mem_ar_valid_o) begin
            mem_ar_valid_o <= 1'b1; // first cycle in MEM_AR
          end else if (mem_ar_ready_i) begin
            mem_ar_valid_o <= 1'b0;
            mem_r_ready_o  <= 1'b1;
            state_q        <= icache_pkg::MEM_R;
          end
        end
        icache_pkg::MEM_R: begin
          if (beat) begin
            mem_r_ready_o <= 1'b0;
            r_valid_o     <= 1'b1; // answer goes out with the beat
            state_q       <= icache_pkg::RESP;
          end
        end
        icache_pkg::RESP: begin
          if (!r_valid_o) begin
            r_valid_o <= 1'b1; // hit path arrives here with valid low
          end else if (r_ready_i) begin
            r_valid_o <= 1'b0;
            state_q   <= icache_pkg::IDLE;
          end
        end
        default: state_q <= icache_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      addr_q <= {ar_addr_i[ADDR_W-1:INDEX_LSB], {icache_pkg::OFFSET_W{1'b0}}};
    end
    if (state_q == icache_pkg::LOOKUP) begin
      victim_q   <= victim;
      rsp_q.resp <= icache_pkg::RESP_OK;
      rsp_q.data <= hit_data; // only kept on a hit
    end
    if (beat) begin
      rsp_q <= mem_r_rsp_i;
    end
  end

endmodule

`default_nettype wire

/* hw/icache_top.sv */
// icache top: controller, two ways, cpu and memory ports
`default_nettype none

module icache_top (
  input  wire logic              clk,
  input  wire logic              rst,
  // cpu side
  input  wire logic              ar_valid_i,
  output wire logic              ar_ready_o,
  input  wire icache_pkg::addr_t ar_addr_i,
  output wire logic              r_valid_o,
  input  wire logic              r_ready_i,
  output wire icache_pkg::rsp_t  r_rsp_o,
  // memory side
  output wire logic              mem_ar_valid_o,
  input  wire logic              mem_ar_ready_i,
  output wire icache_pkg::addr_t mem_ar_addr_o,
  output wire logic              mem_r_ready_o,
  input  wire logic              mem_r_valid_i,
  input  wire icache_pkg::rsp_t  mem_r_rsp_i
);

  wire logic                                    rd_en;
  wire icache_pkg::index_t                      rd_index;
  wire icache_pkg::tag_t                        cmp_tag;
  wire logic [icache_pkg::WAYS-1:0]             fill_en;   // one-hot on refill
  wire icache_pkg::fill_t                       fill;      // shared by all ways
  wire icache_pkg::lookup_t [icache_pkg::WAYS-1:0] lookup;
  wire logic [icache_pkg::WAYS-1:0]             set_valid;

  icache_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_addr_i      (ar_addr_i),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_rsp_o        (r_rsp_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_rsp_i    (mem_r_rsp_i),
    .rd_en_o        (rd_en),
    .rd_index_o     (rd_index),
    .cmp_tag_o      (cmp_tag),
    .fill_en_o      (fill_en),
    .fill_o         (fill),
    .lookup_i       (lookup),
    .set_valid_i    (set_valid)
  );

  for (genvar i = 0; i < icache_pkg::WAYS; i++) begin : g_way
    icache_way u_way (
      .clk         (clk),
      .rst         (rst),
      .rd_en_i     (rd_en),
      .rd_index_i  (rd_index),
      .cmp_tag_i   (cmp_tag),
      .fill_en_i   (fill_en[i]),
      .fill_i      (fill),
      .lookup_o    (lookup[i]),
      .set_valid_o (set_valid[i])
    );
  end

endmodule

`default_nettype wire

/* test/icache_sva.sv */
// handshake assertions for icache_top and the bind that attaches them
`default_nettype none

module icache_sva (
  input wire logic              clk,
  input wire logic              rst,
  input wire logic              ar_ready_i,
  input wire logic              r_valid_i,
  input wire logic              r_ready_i,
  input wire icache_pkg::rsp_t  r_rsp_i,
  input wire logic              mem_ar_valid_i,
  input wire logic              mem_ar_ready_i,
  input wire icache_pkg::addr_t mem_ar_addr_i,
  input wire logic              mem_r_ready_i
);

  a_mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_i && !mem_ar_ready_i |=> $stable(mem_ar_addr_i))
    else $error("memory address changed while mem_ar_valid_o waited");

  a_ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
    !(ar_ready_i && r_valid_i))
    else $error("ar_ready_o and r_valid_o high together");

  a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_rsp_i))
    else $error("cpu response dropped or changed under back-pressure");

  // outputs right after a reset edge
  a_reset_state: assert property (@(posedge clk)
    rst |=> !r_valid_i && !mem_ar_valid_i && !mem_r_ready_i && ar_ready_i)
    else $error("outputs not in their reset state");

endmodule

bind icache_top icache_sva u_sva (
  .clk            (clk),
  .rst            (rst),
  .ar_ready_i     (ar_ready_o),
  .r_valid_i      (r_valid_o),
  .r_ready_i      (r_ready_i),
  .r_rsp_i        (r_rsp_o),
  .mem_ar_valid_i (mem_ar_valid_o),
  .mem_ar_ready_i (mem_ar_ready_i),
  .mem_ar_addr_i  (mem_ar_addr_o),
  .mem_r_ready_i  (mem_r_ready_o)
);

`default_nettype wire

/* test/icache_tb.sv */
// icache testbench with clock, reset, random cpu requests, memory responder, model and checks
`default_nettype none

module icache_tb;

  logic              clk;
  logic              rst;
  logic              ar_valid_i;
  logic              ar_ready_o;
  icache_pkg::addr_t ar_addr_i;
  logic              r_valid_o;
  logic              r_ready_i;
  icache_pkg::rsp_t  r_rsp_o;
  logic              mem_ar_valid_o;
  logic              mem_ar_ready_i;
  icache_pkg::addr_t mem_ar_addr_o;
  logic              mem_r_ready_o;
  logic              mem_r_valid_i;
  icache_pkg::rsp_t  mem_r_rsp_i;

  // reference copy of the tag store
  icache_pkg::tag_t tag_m   [icache_pkg::SETS][icache_pkg::WAYS];
  logic             valid_m [icache_pkg::SETS][icache_pkg::WAYS];
  logic             known_m [icache_pkg::SETS]; // low once a full set has taken a fill

  icache_top dut (
    .clk            (clk),
    .rst            (rst),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_addr_i      (ar_addr_i),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_rsp_o        (r_rsp_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_rsp_i    (mem_r_rsp_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare_values(input logic [95:0] got, input logic [95:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("Fail at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "simulation stopped");
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at time %0t: %s did not happen within 100 cycles", $time, what);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  // small pool of tags per set with sel 2 in the error range
  function automatic icache_pkg::tag_t pool_tag(input int k, input int sel);
    case (sel)
      0:       return icache_pkg::tag_t'(23'h012345 + k);
      1:       return icache_pkg::tag_t'(23'h054321 + 16 * k);
      default: return {7'h7f, 16'(k)};
    endcase
  endfunction

  function automatic icache_pkg::addr_t make_addr(input int k, input int sel,
                                                  input logic [2:0] off);
    icache_pkg::index_t idx;
    idx = icache_pkg::index_t'(9 * k + 2); // spread the pool over the sets
    return {pool_tag(k, sel), idx, off};
  endfunction

  // memory holds the inverted line address twice and errors for tags 7f_xxxx
  function automatic icache_pkg::rsp_t mem_reply(input icache_pkg::addr_t line);
    icache_pkg::rsp_t r;
    r.data = {~line, ~line};
    r.resp = (line[31:25] == 7'h7f) ? 2'b10 : 2'b00;
    return r;
  endfunction

  function automatic logic predict_hit(input icache_pkg::addr_t line);
    logic hit;
    int   w;
    hit = 1'b0;
    for (w = 0; w < icache_pkg::WAYS; w++) begin
      if (valid_m[line[8:3]][w] && (tag_m[line[8:3]][w] == line[31:9])) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic model_fill(input icache_pkg::addr_t line, input icache_pkg::rsp_t rsp);
    logic placed;
    int   w;
    placed = 1'b0;
    if (rsp.resp == 2'b00 && !predict_hit(line)) begin
      for (w = 0; w < icache_pkg::WAYS; w++) begin
        if (!placed && !valid_m[line[8:3]][w]) begin // lowest invalid way first
          valid_m[line[8:3]][w] = 1'b1;
          tag_m[line[8:3]][w]   = line[31:9];
          placed                = 1'b1;
        end
      end
      if (!placed) begin
        known_m[line[8:3]] = 1'b0; // victim comes from the dut counter
      end
    end
  endtask

  // one cpu request that serves the memory side and checks the answer
  task automatic access(input icache_pkg::addr_t addr);
    icache_pkg::addr_t line;
    icache_pkg::addr_t req_addr;
    icache_pkg::rsp_t  exp_rsp;
    icache_pkg::rsp_t  held;
    logic              exp_hit;
    logic              known;
    logic              seen;
    logic              ar_seen;
    logic              done;
    int                cyc;
    int                mem_reqs;
    int                ar_wait;
    int                r_wait;
    int                ar_cyc;
    int                beat_cyc;
    line     = {addr[31:3], 3'b000};
    req_addr = '0;
    exp_rsp  = mem_reply(line);
    exp_hit  = predict_hit(line);
    known    = known_m[line[8:3]];
    held     = '0;
    seen     = 1'b0;
    ar_seen  = 1'b0;
    done     = 1'b0;
    mem_reqs = 0;
    ar_cyc   = 0;
    beat_cyc = 0;
    ar_wait  = $urandom_range(0, 3);
    r_wait   = $urandom_range(0, 3);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    cyc = 0;
    while (!ar_ready_o) begin
      @(posedge clk);
      #1;
      cyc++;
      if (cyc > 100) abort_on_timeout("ar_ready_o");
    end
    @(posedge clk); // accepting edge
    #1;
    ar_valid_i = 1'b0;
    ar_addr_i  = $urandom(); // the cache must hold its own copy
    cyc = 0;
    while (!done) begin
      @(posedge clk);
      #1;
      cyc++;
      if (cyc > 100) abort_on_timeout("the cpu response");
      mem_ar_ready_i = 1'b0;
      mem_r_valid_i  = 1'b0;
      mem_r_rsp_i    = {2'b11, 64'h5a5a_a5a5_0f0f_f0f0}; // junk between beats
      if (r_ready_i) begin
        r_ready_i = 1'b0; // r_valid_o was high at that edge
        done      = 1'b1;
      end else begin
        compare_values(96'(ar_ready_o), 96'(0), "ar_ready_o while busy");
        compare_values(96'(mem_r_ready_o),
                       96'(ar_cyc != 0 && cyc >= ar_cyc && (beat_cyc == 0 || cyc < beat_cyc)),
                       "mem_r_ready_o between the address handshake and the beat");
        if (mem_ar_valid_o) begin
          if (!ar_seen) begin
            ar_seen = 1'b1;
            compare_values(96'(cyc), 96'(2), "edge of mem_ar_valid_o rise");
          end
          if (ar_wait == 0) begin
            req_addr = mem_ar_addr_o;
            compare_values(96'(req_addr), 96'(line), "memory request address");
            mem_ar_ready_i = 1'b1;
            mem_reqs++;
            ar_cyc = cyc + 1;
          end else begin
            ar_wait--;
          end
        end
        if (mem_r_ready_o) begin
          if (r_wait == 0) begin
            mem_r_valid_i = 1'b1;
            mem_r_rsp_i   = mem_reply(req_addr);
            beat_cyc      = cyc + 1;
          end else begin
            r_wait--;
          end
        end
        if (r_valid_o) begin
          if (!seen) begin
            seen = 1'b1;
            held = r_rsp_o;
            compare_values(96'(r_rsp_o), 96'(exp_rsp), "cpu response");
            if (known) begin
              compare_values(96'(mem_reqs == 0), 96'(exp_hit), "hit against model");
            end
            if (mem_reqs == 0) begin
              compare_values(96'(cyc), 96'(2), "hit latency");
            end else begin
              compare_values(96'(mem_reqs), 96'(1), "memory requests on a miss");
              compare_values(96'(cyc), 96'(beat_cyc), "r_valid_o rise on the beat");
            end
          end else begin
            compare_values(96'(r_rsp_o), 96'(held), "cpu response under back-pressure");
          end
          r_ready_i = ($urandom_range(0, 3) != 0);
        end
      end
    end
    compare_values(96'(r_valid_o), 96'(0), "r_valid_o after the handshake");
    compare_values(96'(ar_ready_o), 96'(1), "ar_ready_o after the handshake");
    if (known) begin
      model_fill(line, exp_rsp);
    end
  endtask

  initial begin
    int s;
    int w;
    int i;
    int k;
    int sel;
    void'($urandom(32'hda63));
    rst            = 1'b1;
    ar_valid_i     = 1'b0;
    ar_addr_i      = '0;
    r_ready_i      = 1'b0;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_rsp_i    = '0;
    for (s = 0; s < icache_pkg::SETS; s++) begin
      known_m[s] = 1'b1;
      for (w = 0; w < icache_pkg::WAYS; w++) begin
        valid_m[s][w] = 1'b0;
        tag_m[s][w]   = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    // two tags in one set and then the error tag twice
    access(make_addr(3, 0, 3'd0));
    access(make_addr(3, 1, 3'd5));
    access(make_addr(3, 0, 3'd7));
    access(make_addr(3, 1, 3'd0));
    access(make_addr(3, 2, 3'd0));
    access(make_addr(3, 2, 3'd4));
    for (i = 0; i < 300; i++) begin
      k   = $urandom_range(0, 7);
      sel = $urandom_range(0, 4);
      sel = (sel == 4) ? 2 : sel % 2;
      access(make_addr(k, sel, 3'($urandom_range(0, 7))));
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk);
        #1;
      end
    end
    // three tags in set 63 exercise the counter victim
    for (i = 0; i < 6; i++) begin
      access({23'h020000 + 23'(i % 3), 6'd63, 3'd0});
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hw/icache_pkg.sv
hw/icache_sram.sv
hw/icache_way.sv
hw/icache_ctrl.sv
hw/icache_top.sv
test/icache_sva.sv
test/icache_tb.sv

/* run.sh */
#!/bin/sh
# build the icache testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f list.f --top-module icache_tb \
  -Mdir "$OBJ" -o icache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/icache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
